// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = branch_unit_tb
FILELIST   = list.f
SIM        = obj_dir/V$(TOP)
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== list.f ====
rtl/br_pkg.sv
rtl/br_decode_if.sv
rtl/br_exec_if.sv
rtl/brcond.sv
rtl/br_decode.sv
rtl/br_execute.sv
rtl/br_resolve.sv
rtl/branch_unit.sv
tests/branch_unit_asserts.sv
tests/branch_unit_tb.sv

// ==== rtl/br_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Decode stage of the branch unit
// Opcode classification, B/J/I immediate build, operand select
// First pipeline register, start only for control transfers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module br_decode import br_pkg::*; (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 issue_valid, // Issue strobe
	input  logic [XLEN-1:0]      inst,        // Raw instruction word
	input  logic [XLEN-1:0]      pc,
	input  logic [XLEN-1:0]      rs1_value,
	input  logic [XLEN-1:0]      rs2_value,
	input  logic                 pred_taken,
	input  logic [XLEN-1:0]      pred_target,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	br_decode_if.decode          dec
);

	//////////////////////////////////////////////////////////////////////
	// Field extraction
	//////////////////////////////////////////////////////////////////////

	logic [6:0]      opcode;     // inst[6:0]
	logic [4:0]      rd;         // inst[11:7]
	logic [2:0]      func3;      // inst[14:12]
	logic [XLEN-1:0] imm_b;      // Branch offset
	logic [XLEN-1:0] imm_j;      // JAL offset
	logic [XLEN-1:0] imm_i;      // JALR offset
	logic            recognised; // Opcode handled here
	br_kind_t        kind;
	logic [XLEN-1:0] opa_c;
	logic [XLEN-1:0] opb_c;
	is_packet_t      packet_c;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign func3  = inst[14:12];

	// Sign bit always inst[31], bit 0 implicit zero for B and J
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_i = {{21{inst[31]}}, inst[30:20]};

	//////////////////////////////////////////////////////////////////////
	// Classification and operand select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		recognised = 1'b1;
		kind       = KIND_BRANCH;
		opa_c      = pc;    // PC relative by default
		opb_c      = imm_b;
		case (opcode)
			OPC_BRANCH: begin
				kind  = KIND_BRANCH;
				opb_c = imm_b;
			end
			OPC_JAL: begin
				kind  = KIND_JAL;
				opb_c = imm_j;
			end
			OPC_JALR: begin
				kind  = KIND_JALR;
				opa_c = rs1_value; // Register base
				opb_c = imm_i;
			end
			default: recognised = 1'b0; // Foreign opcode, dropped
		endcase
	end

	// Branches carry no destination, rd field holds offset bits
	always_comb begin
		packet_c             = '0;
		packet_c.pc          = pc;
		packet_c.rob_tag     = rob_tag;
		packet_c.dest_reg    = (kind == KIND_BRANCH) ? 5'd0 : rd;
		packet_c.pred_taken  = pred_taken;
		packet_c.pred_target = pred_target;
		packet_c.kind        = kind;
	end

	//////////////////////////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			dec.start <= 1'b0;
		end else begin
			dec.start <= issue_valid & recognised;
		end
	end

	always_ff @(posedge clock) begin
		dec.opa       <= opa_c;
		dec.opb       <= opb_c;
		dec.rs1       <= rs1_value;
		dec.rs2       <= rs2_value;
		dec.func      <= func3;
		dec.is_packet <= packet_c;
	end

endmodule

// ==== rtl/br_decode_if.sv ====
//////////////////////////////////////////////////////////////////////
// Decode to execute link
// Adder operands, compare values, condition code and issue packet
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface br_decode_if import br_pkg::*; ();

	logic            start;     // One cycle per decoded instruction
	logic [XLEN-1:0] opa;       // Target adder, pc or rs1
	logic [XLEN-1:0] opb;       // Target adder, immediate
	logic [XLEN-1:0] rs1;       // Compare value A
	logic [XLEN-1:0] rs2;       // Compare value B
	logic [2:0]      func;      // Condition code
	is_packet_t      is_packet; // Bookkeeping

	modport decode (
		output start, opa, opb, rs1, rs2, func, is_packet
	);

	modport execute (
		input start, opa, opb, rs1, rs2, func, is_packet
	);

endinterface

// ==== rtl/br_exec_if.sv ====
//////////////////////////////////////////////////////////////////////
// Execute to resolve link
// Condition, computed target, link value and issue packet
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface br_exec_if import br_pkg::*; ();

	logic            done;       // One cycle per evaluated instruction
	logic            cond;       // Taken, forced for jumps
	logic [XLEN-1:0] braddr;     // Target address
	logic [XLEN-1:0] link_value; // pc + INST_BYTES
	is_packet_t      is_packet;  // Bookkeeping

	modport execute (
		output done, cond, braddr, link_value, is_packet
	);

	modport resolve (
		input done, cond, braddr, link_value, is_packet
	);

endinterface

// ==== rtl/br_execute.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage of the branch unit
// Condition evaluation, target add, link value
// Second pipeline register, done follows start
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module br_execute import br_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	br_decode_if.execute dec,
	br_exec_if.execute   exe
);

	logic            br_cond; // Raw comparator result
	logic            cond_c;  // Forced for jumps
	logic [XLEN-1:0] sum;     // opa + opb
	logic [XLEN-1:0] braddr_c;
	logic [XLEN-1:0] link_c;

	brcond i_brcond (
		.rs1  (dec.rs1),
		.rs2  (dec.rs2),
		.func (dec.func),
		.cond (br_cond)
	);

	//////////////////////////////////////////////////////////////////////
	// Target and direction
	//////////////////////////////////////////////////////////////////////

	assign sum = dec.opa + dec.opb;

	// JALR target has bit 0 cleared
	assign braddr_c = (dec.is_packet.kind == KIND_JALR) ? {sum[XLEN-1:1], 1'b0} : sum;

	assign cond_c = (dec.is_packet.kind == KIND_BRANCH) ? br_cond : 1'b1; // Jumps always taken

	assign link_c = dec.is_packet.pc + XLEN'(INST_BYTES); // Return address

	//////////////////////////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			exe.done <= 1'b0;
		end else begin
			exe.done <= dec.start;
		end
	end

	always_ff @(posedge clock) begin
		exe.cond       <= cond_c;
		exe.braddr     <= braddr_c;
		exe.link_value <= link_c;
		exe.is_packet  <= dec.is_packet;
	end

endmodule

// ==== rtl/br_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared definitions for the branch resolution unit
// Data width, RV32I opcode and func3 codes for control transfers
// Instruction kind enum and the issue packet carried down the pipe
//////////////////////////////////////////////////////////////////////

package br_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN       = 32; // Data and address width
	localparam int ROB_TAG_W  = 6;  // ROB entry tag
	localparam int INST_BYTES = 4;  // Sequential PC step

	//////////////////////////////////////////////////////////////////////
	// Major opcodes, inst[6:0]
	//////////////////////////////////////////////////////////////////////

	localparam logic [6:0] OPC_BRANCH = 7'b1100011; // Conditional branches
	localparam logic [6:0] OPC_JAL    = 7'b1101111; // Jump and link
	localparam logic [6:0] OPC_JALR   = 7'b1100111; // Jump and link register

	//////////////////////////////////////////////////////////////////////
	// Branch conditions, inst[14:12]
	//////////////////////////////////////////////////////////////////////

	localparam logic [2:0] FUNC_BEQ  = 3'b000; // Equal
	localparam logic [2:0] FUNC_BNE  = 3'b001; // Not equal
	localparam logic [2:0] FUNC_BLT  = 3'b100; // Signed less than
	localparam logic [2:0] FUNC_BGE  = 3'b101; // Signed greater or equal
	localparam logic [2:0] FUNC_BLTU = 3'b110; // Unsigned less than
	localparam logic [2:0] FUNC_BGEU = 3'b111; // Unsigned greater or equal
	// 010 and 011 are unused and never taken

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		KIND_BRANCH = 2'd0, // Conditional branch
		KIND_JAL    = 2'd1, // PC relative jump
		KIND_JALR   = 2'd2  // Register indirect jump
	} br_kind_t;

	// Per instruction bookkeeping, follows the operands stage by stage
	typedef struct packed {
		logic [XLEN-1:0]      pc;          // Instruction address
		logic [ROB_TAG_W-1:0] rob_tag;     // Completion tag
		logic [4:0]           dest_reg;    // rd, zero for branches
		logic                 pred_taken;  // Front end direction guess
		logic [XLEN-1:0]      pred_target; // Front end target guess
		br_kind_t             kind;        // Branch, JAL or JALR
	} is_packet_t;

endpackage

// ==== rtl/br_resolve.sv ====
//////////////////////////////////////////////////////////////////////
// Resolve stage of the branch unit
// Next PC select, prediction check, link writeback
// Output register, strobes gated by done
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module br_resolve import br_pkg::*; (
	input  logic                 clock,
	input  logic                 rst_n,
	br_exec_if.resolve           exe,
	output logic                 done,     // Completion strobe
	output logic [ROB_TAG_W-1:0] done_tag, // ROB entry completed
	output logic                 taken,    // Actual direction
	output logic [XLEN-1:0]      next_pc,  // Actual next PC
	output logic                 redirect, // Front end guessed wrong
	output logic                 wb_valid, // Link write to rd
	output logic [4:0]           wb_reg,
	output logic [XLEN-1:0]      wb_value
);

	logic [XLEN-1:0] next_pc_c;   // Actual next PC
	logic [XLEN-1:0] pred_next_c; // Predicted next PC
	logic            redirect_c;
	logic            wb_c;

	//////////////////////////////////////////////////////////////////////
	// Prediction check
	//////////////////////////////////////////////////////////////////////

	// Fall through address equals the link value
	assign next_pc_c = exe.cond ? exe.braddr : exe.link_value;

	assign pred_next_c = exe.is_packet.pred_taken ? exe.is_packet.pred_target
	                                              : exe.link_value;

	assign redirect_c = (next_pc_c != pred_next_c);

	// Jumps with rd other than x0
	assign wb_c = (exe.is_packet.kind != KIND_BRANCH) && (exe.is_packet.dest_reg != 5'd0);

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			done     <= 1'b0;
			taken    <= 1'b0;
			redirect <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			done     <= exe.done;
			taken    <= exe.done & exe.cond;
			redirect <= exe.done & redirect_c;
			wb_valid <= exe.done & wb_c;
		end
	end

	always_ff @(posedge clock) begin
		done_tag <= exe.is_packet.rob_tag;
		next_pc  <= next_pc_c;
		wb_reg   <= exe.is_packet.dest_reg; // Zero for branches
		wb_value <= exe.link_value;
	end

endmodule

// ==== rtl/branch_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Branch unit top level
// Decode, execute and resolve stages, three cycle fixed latency
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module branch_unit import br_pkg::*; (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 issue_valid, // Instruction offered
	input  logic [XLEN-1:0]      inst,
	input  logic [XLEN-1:0]      pc,
	input  logic [XLEN-1:0]      rs1_value,
	input  logic [XLEN-1:0]      rs2_value,
	input  logic                 pred_taken,
	input  logic [XLEN-1:0]      pred_target,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	output logic                 done,
	output logic [ROB_TAG_W-1:0] done_tag,
	output logic                 taken,
	output logic [XLEN-1:0]      next_pc,
	output logic                 redirect,
	output logic                 wb_valid,
	output logic [4:0]           wb_reg,
	output logic [XLEN-1:0]      wb_value
);

	br_decode_if dec_if (); // Decode to execute
	br_exec_if   exe_if (); // Execute to resolve

	br_decode i_decode (
		.clock       (clock),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.inst        (inst),
		.pc          (pc),
		.rs1_value   (rs1_value),
		.rs2_value   (rs2_value),
		.pred_taken  (pred_taken),
		.pred_target (pred_target),
		.rob_tag     (rob_tag),
		.dec         (dec_if.decode)
	);

	br_execute i_execute (
		.clock (clock),
		.rst_n (rst_n),
		.dec   (dec_if.execute),
		.exe   (exe_if.execute)
	);

	br_resolve i_resolve (
		.clock    (clock),
		.rst_n    (rst_n),
		.exe      (exe_if.resolve),
		.done     (done),
		.done_tag (done_tag),
		.taken    (taken),
		.next_pc  (next_pc),
		.redirect (redirect),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_value (wb_value)
	);

endmodule

// ==== rtl/brcond.sv ====
//////////////////////////////////////////////////////////////////////
// Branch condition comparator
// Signed and unsigned compares selected by func3
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module brcond import br_pkg::*; (
	input  logic [XLEN-1:0] rs1,  // Compare value A
	input  logic [XLEN-1:0] rs2,  // Compare value B
	input  logic [2:0]      func, // Condition code
	output logic            cond  // 1 when condition holds
);

	logic signed [XLEN-1:0] s_rs1; // Signed views
	logic signed [XLEN-1:0] s_rs2;

	assign s_rs1 = rs1;
	assign s_rs2 = rs2;

	always_comb begin
		case (func)
			FUNC_BEQ:  cond = (rs1 == rs2);
			FUNC_BNE:  cond = (rs1 != rs2);
			FUNC_BLT:  cond = (s_rs1 < s_rs2);
			FUNC_BGE:  cond = (s_rs1 >= s_rs2);
			FUNC_BLTU: cond = (rs1 < rs2);
			FUNC_BGEU: cond = (rs1 >= rs2);
			default:   cond = 1'b0; // 010, 011 never taken
		endcase
	end

endmodule

// ==== tests/branch_unit_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent assertions for the branch unit
// Strobe qualification, writeback register, reset and latency
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module branch_unit_asserts (
	input logic       clock,
	input logic       rst_n,
	input logic       start,    // Decode stage strobe
	input logic       done,
	input logic       redirect,
	input logic       wb_valid,
	input logic [4:0] wb_reg
);

	a_redirect_done: assert property (@(posedge clock) disable iff (!rst_n) redirect |-> done)
		else $error("redirect raised without done");

	a_wb_done: assert property (@(posedge clock) disable iff (!rst_n) wb_valid |-> done)
		else $error("wb_valid raised without done");

	// x0 is never written
	a_wb_reg: assert property (@(posedge clock) disable iff (!rst_n) wb_valid |-> wb_reg != 5'd0)
		else $error("wb_valid raised for x0");

	a_reset_done: assert property (@(posedge clock) !rst_n |=> !done)
		else $error("done high during reset");

	// Execute then resolve register
	a_start_done: assert property (@(posedge clock) disable iff (!rst_n) start |-> ##2 done)
		else $error("done did not follow start after two edges");

endmodule

// ==== tests/branch_unit_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the branch unit
// Clock, reset, LFSR stimulus, reference model and scoreboard queue
// Compare task, watchdog and the assertion bind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module branch_unit_tb;

	localparam int          PERIOD     = 20;
	localparam int          NUM_ISSUES = 2000;
	localparam logic [31:0] SEED       = 32'hf93;
	localparam int          TIMEOUT    = NUM_ISSUES * 2 * PERIOD + 50 * PERIOD; // Gap at most 1 cycle

	typedef struct packed {
		int          due;      // Cycle count when done is expected
		logic [5:0]  tag;
		logic        taken;
		logic [31:0] next_pc;
		logic        redirect;
		logic        wb_valid;
		logic [4:0]  wb_reg;
		logic [31:0] wb_value;
	} expect_t;

	logic        clock, rst_n, issue_valid, pred_taken;
	logic [31:0] inst, pc, rs1_value, rs2_value, pred_target;
	logic [5:0]  rob_tag;
	logic        done, taken, redirect, wb_valid;
	logic [5:0]  done_tag;
	logic [31:0] next_pc, wb_value;
	logic [4:0]  wb_reg;

	logic [31:0] lfsr = SEED;
	int          cycle = 0;
	int          value_errors = 0;
	int          proto_errors = 0;
	expect_t     exp_q[$]; // Expected results in issue order

	branch_unit i_dut (
		.clock       (clock),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.inst        (inst),
		.pc          (pc),
		.rs1_value   (rs1_value),
		.rs2_value   (rs2_value),
		.pred_taken  (pred_taken),
		.pred_target (pred_target),
		.rob_tag     (rob_tag),
		.done        (done),
		.done_tag    (done_tag),
		.taken       (taken),
		.next_pc     (next_pc),
		.redirect    (redirect),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_value    (wb_value)
	);

	bind branch_unit branch_unit_asserts i_asserts (
		.clock    (clock),
		.rst_n    (rst_n),
		.start    (dec_if.start),
		.done     (done),
		.redirect (redirect),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1; // Edge counter for latency

	//////////////////////////////////////////////////////////////////////
	// Random source and reference model
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Edge values half the time
	function automatic logic [31:0] pick_operand();
		logic [31:0] sel;
		sel = rand_bits(3);
		case (sel[2:0])
			3'd0:    return 32'h0000_0000;
			3'd1:    return 32'h7fff_ffff; // Signed max
			3'd2:    return 32'h8000_0000; // Signed min
			3'd3:    return 32'hffff_ffff; // Unsigned max, -1
			default: return rand_bits(32);
		endcase
	endfunction

	function automatic logic branch_holds(input logic [2:0] f, input logic [31:0] a,
		input logic [31:0] b);
		case (f)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return !($signed(a) < $signed(b));
			3'b110:  return a < b;
			3'b111:  return !(a < b);
			default: return 1'b0; // 010, 011
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// Builds one instruction, drives it and queues the expected result
	task automatic issue_one(input int idx);
		logic [31:0] r, imm, target, a, b;
		logic [6:0]  op;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [3:0]  mix;
		logic        jump, known, is_taken;
		expect_t     e;
		a = pick_operand();
		b = pick_operand();
		r = rand_bits(2);
		if (r[1:0] == 2'd0) b = a; // Force equal compare
		r   = rand_bits(5);
		rd  = r[4:0];
		r   = rand_bits(3);
		f3  = r[2:0];
		r   = rand_bits(4);
		mix = r[3:0];
		r   = rand_bits(30);
		pc  = {r[29:0], 2'b00};
		jump  = (mix >= 4'd2 && mix <= 4'd5);
		known = (mix >= 4'd2);
		if (mix < 4'd2) begin // Foreign opcode
			r  = rand_bits(32);
			op = r[6:0];
			if (op == 7'b1100011 || op == 7'b1101111 || op == 7'b1100111) op = 7'b0110011;
			inst   = {r[31:7], op};
			target = '0;
		end else if (mix < 4'd4) begin // JAL
			r      = rand_bits(20);
			imm    = {{11{r[19]}}, r[19:0], 1'b0};
			inst   = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
			target = pc + imm;
		end else if (mix < 4'd6) begin // JALR
			r      = rand_bits(12);
			imm    = {{20{r[11]}}, r[11:0]};
			inst   = {imm[11:0], 5'd1, 3'b000, rd, 7'b1100111};
			target = (a + imm) & ~32'd1;
		end else begin // Conditional branch
			r      = rand_bits(12);
			imm    = {{19{r[11]}}, r[11:0], 1'b0};
			inst   = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
			target = pc + imm;
		end
		is_taken = jump ? 1'b1 : (known && branch_holds(f3, a, b));
		r = rand_bits(2);
		pred_taken  = r[0];
		pred_target = r[1] ? target : rand_bits(32); // Correct or wild guess
		issue_valid = 1'b1;
		rs1_value   = a;
		rs2_value   = b;
		rob_tag     = idx[5:0];
		e.due      = cycle + 3;
		e.tag      = idx[5:0];
		e.taken    = is_taken;
		e.next_pc  = is_taken ? target : pc + 32'd4;
		e.redirect = e.next_pc != (pred_taken ? pred_target : pc + 32'd4);
		e.wb_valid = jump && (rd != 5'd0);
		e.wb_reg   = rd;
		e.wb_value = pc + 32'd4;
		if (known) exp_q.push_back(e);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Scoreboard, sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		expect_t e;
		if (rst_n === 1'b1) begin
			if ((redirect === 1'b1 || wb_valid === 1'b1) && done !== 1'b1) begin
				$display("Redirect or writeback raised without done at %0t", $time);
				proto_errors++;
			end
			if (done === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("done raised at %0t with no instruction outstanding", $time);
					proto_errors++;
				end else begin
					e = exp_q.pop_front();
					check("done cycle", cycle, e.due);
					check("done_tag", 32'(done_tag), 32'(e.tag));
					check("taken", 32'(taken), 32'(e.taken));
					check("next_pc", next_pc, e.next_pc);
					check("redirect", 32'(redirect), 32'(e.redirect));
					check("wb_valid", 32'(wb_valid), 32'(e.wb_valid));
					if (e.wb_valid) begin
						check("wb_reg", 32'(wb_reg), 32'(e.wb_reg));
						check("wb_value", wb_value, e.wb_value);
					end
				end
			end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
				$display("done missing at %0t for rob_tag %0d", $time, exp_q[0].tag);
				proto_errors++;
				void'(exp_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		inst        = '0;
		pc          = '0;
		rs1_value   = '0;
		rs2_value   = '0;
		pred_taken  = 1'b0;
		pred_target = '0;
		rob_tag     = '0;
		repeat (3) @(posedge clock);
		#2 rst_n = 1'b1;
		for (int i = 0; i < NUM_ISSUES; i++) begin
			r = rand_bits(2);
			if (r[1:0] == 2'd0) begin // One idle cycle
				@(posedge clock);
				#2 issue_valid = 1'b0;
			end
			@(posedge clock);
			#2 issue_one(i);
		end
		@(posedge clock);
		#2 issue_valid = 1'b0;
		repeat (6) @(posedge clock); // Drain the pipe
		@(negedge clock);
		if (exp_q.size() != 0) begin
			$display("%0d expected results never completed", exp_q.size());
			proto_errors++;
		end
		$display("Errors: %0d value mismatches, %0d protocol errors", value_errors, proto_errors);
		if (value_errors + proto_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout, the run did not finish within %0d ns", TIMEOUT);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
